/* tlu_pkg.sv */
package tlu_pkg;

    // trigger modes as encoded in conf0[1:0]
    typedef enum logic [1:0]
    {
        mode_disabled         = 2'd0,
        mode_no_handshake     = 2'd1,
        mode_simple_handshake = 2'd2,
        mode_data_handshake   = 2'd3
    } tlu_mode_e;

    // handshake FSM states
    typedef enum logic [2:0]
    {
        st_idle     = 3'd0,
        st_wait_low = 3'd1,
        st_delay    = 3'd2,
        st_shift    = 3'd3,
        st_write    = 3'd4
    } tlu_state_e;

    // static configuration from the register bank
    typedef struct packed
    {
        tlu_mode_e  mode;
        logic       msb_first;
        logic       disable_veto;
        logic [3:0] data_delay;
        // 0 selects 32 clock periods
        logic [4:0] clock_cycles;
        logic       enable_reset;
        logic       invert_lemo;
        logic [7:0] low_timeout;
    } tlu_cfg_t;

    // synchronized TLU lines after connector selection
    typedef struct packed
    {
        logic trigger;
        logic reset;
        logic veto;
        logic trigger_flag;
        logic reset_flag;
        logic rj45_enabled;
    } tlu_lines_t;

    // one FIFO word per accepted trigger
    typedef struct packed
    {
        logic        valid_marker;
        logic [30:0] number;
    } tlu_word_t;

    // register map, byte addresses
    localparam logic [3:0] reg_soft_rst = 4'd0;
    localparam logic [3:0] reg_conf0    = 4'd1;
    localparam logic [3:0] reg_conf1    = 4'd2;
    localparam logic [3:0] reg_timeout  = 4'd3;
    localparam logic [3:0] reg_tlu_num0 = 4'd4;
    localparam logic [3:0] reg_set_num0 = 4'd8;
    localparam logic [3:0] reg_status   = 4'd12;

    // bits of reg_status
    localparam int status_timeout_bit = 0;
    localparam int status_rj45_bit    = 1;

endpackage

/* tlu_input_sync.sv */
`timescale 1ns/1ps

module tlu_input_sync
    import tlu_pkg::*;
(
    input  logic       bus_clk,
    input  logic       rst,
    input  logic       rj45_trigger,
    input  logic       lemo_trigger,
    input  logic       rj45_reset,
    input  logic       lemo_reset,
    input  logic       ext_veto,
    input  tlu_cfg_t   cfg,
    output tlu_lines_t lines
);

    logic [4:0] pins;
    logic [4:0] sync1;
    logic [4:0] sync2;
    logic [4:0] sync3;
    logic       rj45_trg_s;
    logic       lemo_trg_s;
    logic       rj45_rst_s;
    logic       lemo_rst_s;
    logic       veto_s;
    logic       rj45_en;
    logic       trig_lvl;
    logic       rst_lvl;
    logic       trig_q;
    logic       rst_q;
    logic       trig_flag;
    logic       rst_flag;

    // lemo trigger polarity fixed before the synchronizer
    assign pins = {ext_veto, lemo_reset, rj45_reset, lemo_trigger ^ cfg.invert_lemo,
                   rj45_trigger};

    // three flop stages per pin, all five pins side by side
    always_ff @(posedge bus_clk)
    begin
        sync1 <= pins;
        sync2 <= sync1;
        sync3 <= sync2;
    end

    assign rj45_trg_s = sync3[0];
    assign lemo_trg_s = sync3[1];
    assign rj45_rst_s = sync3[2];
    assign lemo_rst_s = sync3[3];
    assign veto_s     = sync3[4];

    // unplugged rj45 reads high on trigger and reset
    // once enabled it stays until the mode goes to disabled
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            rj45_en <= 1'b0;
        else if (cfg.mode == mode_disabled || (rj45_trg_s && rj45_rst_s && !rj45_en))
            rj45_en <= 1'b0;
        else
            rj45_en <= 1'b1;
    end

    // connector select
    assign trig_lvl = rj45_en ? rj45_trg_s : lemo_trg_s;
    assign rst_lvl  = rj45_en ? rj45_rst_s : lemo_rst_s;

    // registered rising edge flags, one cycle behind the levels
    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            trig_q    <= 1'b0;
            rst_q     <= 1'b0;
            trig_flag <= 1'b0;
            rst_flag  <= 1'b0;
        end
        else
        begin
            trig_q    <= trig_lvl;
            rst_q     <= rst_lvl;
            trig_flag <= trig_lvl && !trig_q;
            rst_flag  <= rst_lvl && !rst_q;
        end
    end

    assign lines.trigger      = trig_lvl;
    assign lines.reset        = rst_lvl;
    assign lines.veto         = veto_s;
    assign lines.trigger_flag = trig_flag;
    assign lines.reset_flag   = rst_flag;
    assign lines.rj45_enabled = rj45_en;

endmodule

/* tlu_handshake_fsm.sv */
`timescale 1ns/1ps

module tlu_handshake_fsm
    import tlu_pkg::*;
#(
    parameter int DIVISOR = 12
)
(
    input  logic        bus_clk,
    input  logic        rst,
    input  tlu_cfg_t    cfg,
    input  tlu_lines_t  lines,
    input  logic        preset_load,
    input  logic [31:0] preset_value,
    input  logic        fifo_full,
    output logic        tlu_busy,
    output logic        tlu_clock,
    output logic        fifo_wr,
    output tlu_word_t   fifo_word,
    output logic        number_valid,
    output logic [31:0] tlu_number,
    output logic        timeout_err
);

    // half period of the tlu clock in bus_clk cycles
    localparam int HALF = DIVISOR / 2;
    localparam int DW   = $clog2(HALF);

    tlu_state_e    state;
    logic [7:0]    cycle_cnt;
    logic [DW-1:0] div_cnt;
    logic [4:0]    bit_cnt;
    logic [4:0]    last_bit;
    logic [31:0]   trig_count;
    logic [31:0]   count_inc;
    logic [31:0]   capture;
    logic          accept;
    logic          start;
    logic          timeout_hit;
    logic          div_end;
    logic          clk_fall;

    // veto only blocks while disable_veto is clear
    assign accept = lines.trigger_flag && (cfg.mode != mode_disabled) &&
                    (!lines.veto || cfg.disable_veto);
    assign start  = (state == st_idle) && accept;

    // low_timeout of 0 turns the check off
    assign timeout_hit = (cfg.low_timeout != 8'd0) && (cycle_cnt == cfg.low_timeout - 8'd1);

    // clock_cycles 0 wraps to 31, i.e. 32 periods
    assign last_bit = cfg.clock_cycles - 5'd1;
    assign div_end  = (div_cnt == DW'(HALF - 1));
    assign clk_fall = (state == st_shift) && div_end && tlu_clock;

    // saturating increment
    assign count_inc = (trig_count == '1) ? trig_count : trig_count + 32'd1;

    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            state       <= st_idle;
            cycle_cnt   <= '0;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            tlu_clock   <= 1'b0;
            timeout_err <= 1'b0;
        end
        else
        begin
            timeout_err <= 1'b0;
            case (state)
                st_idle:
                begin
                    cycle_cnt <= '0;
                    div_cnt   <= '0;
                    bit_cnt   <= '0;
                    tlu_clock <= 1'b0;
                    if (accept)
                        state <= (cfg.mode == mode_no_handshake) ? st_write : st_wait_low;
                end
                // tlu drops trigger once it sees busy
                st_wait_low:
                begin
                    cycle_cnt <= cycle_cnt + 8'd1;
                    if (!lines.trigger)
                    begin
                        cycle_cnt <= '0;
                        if (cfg.mode != mode_data_handshake)
                            state <= st_write;
                        else if (cfg.data_delay == 4'd0)
                            state <= st_shift;
                        else
                            state <= st_delay;
                    end
                    else if (timeout_hit)
                    begin
                        timeout_err <= 1'b1;
                        state       <= st_idle;
                    end
                end
                st_delay:
                begin
                    cycle_cnt <= cycle_cnt + 8'd1;
                    if (cycle_cnt == {4'd0, cfg.data_delay} - 8'd1)
                        state <= st_shift;
                end
                // low half first, sample on each falling edge
                st_shift:
                begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_end)
                    begin
                        div_cnt   <= '0;
                        tlu_clock <= !tlu_clock;
                        if (tlu_clock)
                        begin
                            bit_cnt <= bit_cnt + 5'd1;
                            if (bit_cnt == last_bit)
                                state <= st_write;
                        end
                    end
                end
                // waits here while the fifo is full
                st_write:
                begin
                    if (!fifo_full)
                        state <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // internal trigger counter, tlu reset beats a preset
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            trig_count <= '0;
        else if (lines.reset_flag && cfg.enable_reset)
            trig_count <= '0;
        else if (preset_load)
            trig_count <= preset_value;
        else if (start && cfg.mode == mode_no_handshake)
            trig_count <= count_inc;
    end

    // number to be written, counter based or shifted in
    always_ff @(posedge bus_clk)
    begin
        if (start)
            capture <= (cfg.mode == mode_data_handshake) ? 32'd0 : count_inc;
        else if (clk_fall)
        begin
            if (cfg.msb_first)
                capture <= {capture[30:0], lines.trigger};
            else
                capture[bit_cnt] <= lines.trigger;
        end
    end

    // busy also covers a stalled write in no-handshake mode
    assign tlu_busy = (state != st_idle) &&
                      ((cfg.mode != mode_no_handshake) || fifo_full);

    assign fifo_wr                = (state == st_write) && !fifo_full;
    assign fifo_word.valid_marker = 1'b1;
    assign fifo_word.number       = capture[30:0];
    assign number_valid           = fifo_wr && (cfg.mode == mode_data_handshake);
    assign tlu_number             = capture;

    // tlu must see busy for the whole handshake
    busy_during_handshake: assert property (@(posedge bus_clk) disable iff (rst)
        (state inside {st_wait_low, st_delay, st_shift}) |-> tlu_busy);

    // clock idles low between triggers
    clock_low_in_idle: assert property (@(posedge bus_clk) disable iff (rst)
        (state == st_idle) |-> !tlu_clock);

endmodule

/* tlu_register_file.sv */
`timescale 1ns/1ps

module tlu_register_file
    import tlu_pkg::*;
(
    input  logic        bus_clk,
    input  logic        rst,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_rd,
    input  logic        bus_wr,
    input  logic        number_valid,
    input  logic [31:0] tlu_number,
    input  logic        timeout_err,
    input  logic        rj45_enabled,
    output logic [7:0]  bus_data_out,
    output tlu_cfg_t    cfg,
    output logic        soft_rst,
    output logic        preset_load,
    output logic [31:0] preset_value
);

    logic [7:0]  conf0;
    logic [7:0]  conf1;
    logic [7:0]  timeout;
    logic [31:0] tlu_num;
    logic [31:0] set_num;
    logic        err_sticky;
    logic        addr_ok;
    logic [3:0]  addr;
    logic        wr_hit;

    // only the lowest 16 addresses are decoded
    assign addr_ok = (bus_add[15:4] == 12'd0);
    assign addr    = bus_add[3:0];
    assign wr_hit  = bus_wr && addr_ok;

    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            conf0       <= '0;
            conf1       <= '0;
            timeout     <= '0;
            set_num     <= '0;
            tlu_num     <= '0;
            err_sticky  <= 1'b0;
            soft_rst    <= 1'b0;
            preset_load <= 1'b0;
        end
        else
        begin
            // pulses one cycle after the bus write
            soft_rst    <= wr_hit && (addr == reg_soft_rst);
            preset_load <= wr_hit && (addr == reg_set_num0 + 4'd3);
            if (wr_hit)
            begin
                case (addr)
                    reg_conf0:           conf0         <= bus_data_in;
                    reg_conf1:           conf1         <= bus_data_in;
                    reg_timeout:         timeout       <= bus_data_in;
                    reg_set_num0:        set_num[7:0]   <= bus_data_in;
                    reg_set_num0 + 4'd1: set_num[15:8]  <= bus_data_in;
                    reg_set_num0 + 4'd2: set_num[23:16] <= bus_data_in;
                    reg_set_num0 + 4'd3: set_num[31:24] <= bus_data_in;
                    default:             ;
                endcase
            end
            if (number_valid)
                tlu_num <= tlu_number;
            // cleared only by reset
            if (timeout_err)
                err_sticky <= 1'b1;
        end
    end

    // registered read, holds without rd
    always_ff @(posedge bus_clk)
    begin
        if (rst)
            bus_data_out <= '0;
        else if (bus_rd)
        begin
            bus_data_out <= '0;
            if (addr_ok)
            begin
                case (addr)
                    reg_conf0:           bus_data_out <= conf0;
                    reg_conf1:           bus_data_out <= conf1;
                    reg_timeout:         bus_data_out <= timeout;
                    reg_tlu_num0:        bus_data_out <= tlu_num[7:0];
                    reg_tlu_num0 + 4'd1: bus_data_out <= tlu_num[15:8];
                    reg_tlu_num0 + 4'd2: bus_data_out <= tlu_num[23:16];
                    reg_tlu_num0 + 4'd3: bus_data_out <= tlu_num[31:24];
                    reg_set_num0:        bus_data_out <= set_num[7:0];
                    reg_set_num0 + 4'd1: bus_data_out <= set_num[15:8];
                    reg_set_num0 + 4'd2: bus_data_out <= set_num[23:16];
                    reg_set_num0 + 4'd3: bus_data_out <= set_num[31:24];
                    reg_status:
                    begin
                        bus_data_out[status_timeout_bit] <= err_sticky;
                        bus_data_out[status_rj45_bit]    <= rj45_enabled;
                    end
                    default:             ;
                endcase
            end
        end
    end

    // field map of the config bytes, conf1[7] is spare
    assign cfg.mode         = tlu_mode_e'(conf0[1:0]);
    assign cfg.msb_first    = conf0[2];
    assign cfg.disable_veto = conf0[3];
    assign cfg.data_delay   = conf0[7:4];
    assign cfg.clock_cycles = conf1[4:0];
    assign cfg.enable_reset = conf1[5];
    assign cfg.invert_lemo  = conf1[6];
    assign cfg.low_timeout  = timeout;
    assign preset_value     = set_num;

    // soft reset loops back through the block reset and clears itself
    soft_rst_single_cycle: assert property (@(posedge bus_clk) soft_rst |=> !soft_rst);

endmodule

/* tlu_event_fifo.sv */
`timescale 1ns/1ps

module tlu_event_fifo
    import tlu_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
)
(
    input  logic      bus_clk,
    input  logic      rst,
    input  logic      wr_en,
    input  tlu_word_t wr_word,
    input  logic      rd_en,
    output tlu_word_t rd_word,
    output logic      empty,
    output logic      full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    tlu_word_t     mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // words in mem, the head register not included
    logic [AW:0]   count;
    logic          head_valid;
    logic          push;
    logic          load;

    assign push  = wr_en && !full;
    // refill head when it is free or being popped
    assign load  = (count != '0) && (!head_valid || rd_en);
    assign full  = (count == (AW + 1)'(FIFO_DEPTH));
    assign empty = !head_valid;

    always_ff @(posedge bus_clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_word;
        if (load)
            rd_word <= mem[rd_ptr];
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge bus_clk)
    begin
        if (rst)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (load)
            begin
                rd_ptr     <= rd_ptr + 1'b1;
                head_valid <= 1'b1;
            end
            else if (rd_en)
                head_valid <= 1'b0;
            case ({push, load})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // the FSM holds its word in st_write while full
    no_write_when_full: assert property (@(posedge bus_clk) disable iff (rst)
        full |-> !wr_en);

endmodule

/* tlu_controller_top.sv */
`timescale 1ns/1ps

module tlu_controller_top
    import tlu_pkg::*;
#(
    parameter int DIVISOR    = 12,
    parameter int FIFO_DEPTH = 16
)
(
    input  logic        bus_clk,
    input  logic        rst,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_rd,
    input  logic        bus_wr,
    output logic [7:0]  bus_data_out,
    input  logic        fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data,
    input  logic        rj45_trigger,
    input  logic        lemo_trigger,
    input  logic        rj45_reset,
    input  logic        lemo_reset,
    input  logic        ext_veto,
    output logic        rj45_enabled,
    output logic        tlu_busy,
    output logic        tlu_clock
);

    tlu_cfg_t    cfg;
    tlu_lines_t  lines;
    tlu_word_t   wr_word;
    tlu_word_t   head_word;
    logic        soft_rst;
    logic        blk_rst;
    logic        preset_load;
    logic [31:0] preset_value;
    logic        fifo_wr;
    logic        fifo_full;
    logic        number_valid;
    logic [31:0] tlu_number;
    logic        timeout_err;

    // bus reset or a write to address 0
    assign blk_rst = rst | soft_rst;

    tlu_register_file tlu_register_file_i (
        .bus_clk      (bus_clk),
        .rst          (blk_rst),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .number_valid (number_valid),
        .tlu_number   (tlu_number),
        .timeout_err  (timeout_err),
        .rj45_enabled (lines.rj45_enabled),
        .bus_data_out (bus_data_out),
        .cfg          (cfg),
        .soft_rst     (soft_rst),
        .preset_load  (preset_load),
        .preset_value (preset_value)
    );

    tlu_input_sync tlu_input_sync_i (
        .bus_clk      (bus_clk),
        .rst          (blk_rst),
        .rj45_trigger (rj45_trigger),
        .lemo_trigger (lemo_trigger),
        .rj45_reset   (rj45_reset),
        .lemo_reset   (lemo_reset),
        .ext_veto     (ext_veto),
        .cfg          (cfg),
        .lines        (lines)
    );

    tlu_handshake_fsm #(
        .DIVISOR (DIVISOR)
    ) tlu_handshake_fsm_i (
        .bus_clk      (bus_clk),
        .rst          (blk_rst),
        .cfg          (cfg),
        .lines        (lines),
        .preset_load  (preset_load),
        .preset_value (preset_value),
        .fifo_full    (fifo_full),
        .tlu_busy     (tlu_busy),
        .tlu_clock    (tlu_clock),
        .fifo_wr      (fifo_wr),
        .fifo_word    (wr_word),
        .number_valid (number_valid),
        .tlu_number   (tlu_number),
        .timeout_err  (timeout_err)
    );

    tlu_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) tlu_event_fifo_i (
        .bus_clk (bus_clk),
        .rst     (blk_rst),
        .wr_en   (fifo_wr),
        .wr_word (wr_word),
        .rd_en   (fifo_read),
        .rd_word (head_word),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    assign fifo_data    = head_word;
    assign rj45_enabled = lines.rj45_enabled;

endmodule

/* tb_tlu_controller.sv */
`timescale 1ns/1ps

module tb_tlu_controller
    import tlu_pkg::*;
();

    logic        bus_clk = 1'b0;
    logic        rst;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_data_out;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic        rj45_trigger;
    logic        lemo_trigger;
    logic        rj45_reset;
    logic        lemo_reset;
    logic        ext_veto;
    logic        rj45_enabled;
    logic        tlu_busy;
    logic        tlu_clock;

    int          checks = 0;
    int          mismatches = 0;
    int          timeouts = 0;
    logic [31:0] lcg_state;
    // expected counter value after presets, tlu resets and accepted triggers
    logic [31:0] exp_count;
    logic [31:0] scoreboard [$];
    // set from busy rising up to the last tlu_clock fall of a data handshake
    logic        in_shift = 1'b0;

    tlu_controller_top #(
        .DIVISOR    (12),
        .FIFO_DEPTH (16)
    ) tlu_controller_top_i (
        .bus_clk      (bus_clk),
        .rst          (rst),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_out (bus_data_out),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .rj45_trigger (rj45_trigger),
        .lemo_trigger (lemo_trigger),
        .rj45_reset   (rj45_reset),
        .lemo_reset   (lemo_reset),
        .ext_veto     (ext_veto),
        .rj45_enabled (rj45_enabled),
        .tlu_busy     (tlu_busy),
        .tlu_clock    (tlu_clock)
    );

    // 4 ns period
    always #2 bus_clk = ~bus_clk;

    // busy has to cover both halves of every tlu_clock period
    busy_through_shift: assert property (@(posedge bus_clk) disable iff (rst)
        (in_shift || tlu_clock) |-> tlu_busy)
    else
    begin
        $display("Mismatch at %0t: tlu_busy got %0b expected 1", $time, tlu_busy);
        mismatches++;
    end

    // rj45 pins sit high like an unplugged cable so lemo stays selected
    lemo_selected: assert property (@(posedge bus_clk) disable iff (rst) !rj45_enabled)
    else
    begin
        $display("Mismatch at %0t: rj45_enabled got %0b expected 0", $time, rj45_enabled);
        mismatches++;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] bit_reverse16(input logic [15:0] value);
        logic [15:0] result;
        for (int k = 0; k < 16; k++)
            result[k] = value[15 - k];
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            mismatches++;
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge bus_clk);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge bus_clk);
        bus_wr      <= 1'b0;
    endtask

    // data is registered on the edge that samples rd
    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(posedge bus_clk);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge bus_clk);
        bus_rd  <= 1'b0;
        @(negedge bus_clk);
        data = bus_data_out;
    endtask

    task automatic check_reg(input logic [15:0] addr, input logic [7:0] expected);
        logic [7:0] data;
        bus_read(addr, data);
        check_value($sformatf("bus_data_out[addr %0d]", addr), data, expected);
    endtask

    task automatic read_tlu_number(output logic [31:0] value);
        logic [7:0] data;
        value = '0;
        for (int k = 0; k < 4; k++)
        begin
            bus_read(16'(reg_tlu_num0 + k), data);
            value[k*8 +: 8] = data;
        end
    endtask

    task automatic wait_busy_level(input logic level, input int limit);
        int n;
        n = 0;
        do
        begin
            @(negedge bus_clk);
            n++;
        end
        while (tlu_busy !== level && n < limit);
        if (tlu_busy !== level)
        begin
            $display("Timeout at %0t: tlu_busy did not go to %0b", $time, level);
            timeouts++;
        end
    endtask

    task automatic wait_clock_level(input logic level, input int limit);
        int n;
        n = 0;
        do
        begin
            @(negedge bus_clk);
            n++;
        end
        while (tlu_clock !== level && n < limit);
        if (tlu_clock !== level)
        begin
            $display("Timeout at %0t: tlu_clock did not go to %0b", $time, level);
            timeouts++;
        end
    endtask

    task automatic wait_fifo_data(input int limit);
        int n;
        n = 0;
        do
        begin
            @(negedge bus_clk);
            n++;
        end
        while (fifo_empty !== 1'b0 && n < limit);
        if (fifo_empty !== 1'b0)
        begin
            $display("Timeout at %0t: no word arrived in the FIFO", $time);
            timeouts++;
        end
    endtask

    // short lemo pulse that outlasts the 3 sync stages and the edge flag
    task automatic send_plain_trigger(input logic accepted);
        @(posedge bus_clk);
        lemo_trigger <= 1'b1;
        repeat (6) @(posedge bus_clk);
        lemo_trigger <= 1'b0;
        repeat (8) @(posedge bus_clk);
        if (accepted)
        begin
            exp_count = exp_count + 32'd1;
            scoreboard.push_back({1'b1, exp_count[30:0]});
        end
    endtask

    // TLU side of the data handshake with one bit per tlu_clock rising edge
    task automatic send_data_trigger(input logic [15:0] number);
        @(posedge bus_clk);
        lemo_trigger <= 1'b1;
        wait_busy_level(1'b1, 40);
        in_shift = 1'b1;
        @(posedge bus_clk);
        lemo_trigger <= 1'b0;
        for (int k = 0; k < 16; k++)
        begin
            wait_clock_level(1'b1, 200);
            @(posedge bus_clk);
            lemo_trigger <= number[k];
            wait_clock_level(1'b0, 200);
        end
        in_shift = 1'b0;
        wait_busy_level(1'b0, 100);
        @(posedge bus_clk);
        lemo_trigger <= 1'b0;
        repeat (6) @(posedge bus_clk);
    endtask

    // pop every expected word in order and expect an empty FIFO after
    task automatic drain_fifo();
        logic [31:0] expected;
        while (scoreboard.size() > 0)
        begin
            expected = scoreboard.pop_front();
            wait_fifo_data(100);
            check_value("fifo_data", fifo_data, expected);
            @(posedge bus_clk);
            fifo_read <= 1'b1;
            @(posedge bus_clk);
            fifo_read <= 1'b0;
        end
        @(negedge bus_clk);
        check_value("fifo_empty", fifo_empty, 32'd1);
    endtask

    initial
    begin
        logic [31:0] preset;
        logic [31:0] number;
        logic [31:0] capture;
        logic [31:0] word;
        logic        saw_busy;

        rst          = 1'b1;
        bus_add      = '0;
        bus_data_in  = '0;
        bus_rd       = 1'b0;
        bus_wr       = 1'b0;
        fifo_read    = 1'b0;
        rj45_trigger = 1'b1;
        rj45_reset   = 1'b1;
        lemo_trigger = 1'b0;
        lemo_reset   = 1'b0;
        ext_veto     = 1'b0;
        lcg_state    = 32'h912a6b01;
        exp_count    = '0;

        repeat (3) @(posedge bus_clk);
        rst <= 1'b0;
        @(negedge bus_clk);
        check_value("tlu_busy", tlu_busy, 32'd0);
        check_value("tlu_clock", tlu_clock, 32'd0);
        check_value("fifo_empty", fifo_empty, 32'd1);
        check_value("rj45_enabled", rj45_enabled, 32'd0);
        check_reg(reg_status, 8'h00);

        // config readback while the mode stays disabled
        bus_write(reg_conf0, 8'h34);
        check_reg(reg_conf0, 8'h34);
        bus_write(reg_conf1, 8'h2a);
        check_reg(reg_conf1, 8'h2a);
        bus_write(reg_timeout, 8'hc3);
        check_reg(reg_timeout, 8'hc3);
        bus_write(reg_soft_rst, 8'h00);
        check_reg(reg_conf0, 8'h00);
        check_reg(reg_conf1, 8'h00);
        check_reg(reg_timeout, 8'h00);
        exp_count = '0;

        // no handshake mode with a counter preset through bytes 8 to 11
        lcg_state = lcg_next(lcg_state);
        preset    = lcg_state & 32'h0fff_ffff;
        bus_write(reg_conf0, 8'h01);
        for (int k = 0; k < 4; k++)
            bus_write(16'(reg_set_num0 + k), preset[k*8 +: 8]);
        repeat (2) @(posedge bus_clk);
        exp_count = preset;
        repeat (3) send_plain_trigger(1'b1);
        drain_fifo();

        // data handshake with 16 clocks and delay 2 in both bit orders
        bus_write(reg_conf1, 8'h10);
        for (int order = 0; order < 2; order++)
        begin
            lcg_state = lcg_next(lcg_state);
            number    = {16'd0, lcg_state[31:16]};
            capture   = (order == 1) ? {16'd0, bit_reverse16(number[15:0])} : number;
            bus_write(reg_conf0, (order == 1) ? 8'h27 : 8'h23);
            scoreboard.push_back(32'h8000_0000 | capture);
            send_data_trigger(number[15:0]);
            drain_fifo();
            read_tlu_number(word);
            check_value("tlu_number", word, capture);
        end

        // veto blocks triggers unless disable_veto is set
        bus_write(reg_conf0, 8'h01);
        @(posedge bus_clk);
        ext_veto <= 1'b1;
        repeat (5) @(posedge bus_clk);
        repeat (2) send_plain_trigger(1'b0);
        repeat (10) @(posedge bus_clk);
        @(negedge bus_clk);
        check_value("fifo_empty", fifo_empty, 32'd1);
        bus_write(reg_conf0, 8'h09);
        send_plain_trigger(1'b1);
        drain_fifo();
        @(posedge bus_clk);
        ext_veto <= 1'b0;

        // tlu reset pulse clears the counter
        bus_write(reg_conf0, 8'h01);
        bus_write(reg_conf1, 8'h20);
        @(posedge bus_clk);
        lemo_reset <= 1'b1;
        repeat (6) @(posedge bus_clk);
        lemo_reset <= 1'b0;
        repeat (6) @(posedge bus_clk);
        exp_count = '0;
        send_plain_trigger(1'b1);
        drain_fifo();

        // simple handshake where the trigger never drops and times out after 20 cycles
        bus_write(reg_conf1, 8'h00);
        bus_write(reg_timeout, 8'd20);
        bus_write(reg_conf0, 8'h02);
        @(posedge bus_clk);
        lemo_trigger <= 1'b1;
        saw_busy = 1'b0;
        repeat (60)
        begin
            @(negedge bus_clk);
            if (tlu_busy)
                saw_busy = 1'b1;
        end
        check_value("tlu_busy seen", saw_busy, 32'd1);
        check_value("tlu_busy", tlu_busy, 32'd0);
        @(posedge bus_clk);
        lemo_trigger <= 1'b0;
        repeat (8) @(posedge bus_clk);
        @(negedge bus_clk);
        check_value("fifo_empty", fifo_empty, 32'd1);
        check_reg(reg_status, 8'h01);

        $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
                 checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* all.f */
tlu_pkg.sv
tlu_input_sync.sv
tlu_handshake_fsm.sv
tlu_register_file.sv
tlu_event_fifo.sv
tlu_controller_top.sv
tb_tlu_controller.sv

/* Bender.yml */
package:
  name: tlu_controller

sources:
  - tlu_pkg.sv
  - tlu_input_sync.sv
  - tlu_handshake_fsm.sv
  - tlu_register_file.sv
  - tlu_event_fifo.sv
  - tlu_controller_top.sv
  - target: test
    files:
      - tb_tlu_controller.sv
